// ==== src.f ====
source/i2c_pkg.sv
source/i2c_line_filter.sv
source/i2c_scl_timer.sv
source/i2c_byte_engine.sv
source/cpld_write_sequencer.sv
source/cpld_led_ctrl_top.sv
bench/i2c_target_model.sv
bench/tb_cpld_led_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_cpld_led_ctrl
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== bench/tb_cpld_led_ctrl.sv ====
`timescale 1ns/1ps

module tb_cpld_led_ctrl;

    localparam int QDIV        = 4;
    localparam int ROWS        = 6;
    localparam int POST_CYCLES = 40;
    // Each row gets 200 quarters, well over one transaction, plus idle cycles
    localparam int WATCHDOG_NS = ROWS * (200 * QDIV + 100) * 8 + 16 * 8;

    // Bytes the target must see on the bus in order
    localparam logic [7:0] EXP_BYTE0 = 8'h7C;
    localparam logic [7:0] EXP_BYTE1 = 8'h02;
    localparam logic [7:0] EXP_BYTE2 = 8'h01;

    logic       clk;
    logic       reset;
    logic       start_i;
    logic       scl_low;
    logic       sda_low_dut;
    logic       sda_low_model;
    logic       busy;
    logic       done;
    logic       nack;
    logic       scl_bus;
    logic       sda_bus;
    logic       clear;
    logic [3:0] nack_at;
    logic [3:0] byte_count;
    logic [7:0] byte0;
    logic [7:0] byte1;
    logic [7:0] byte2;
    logic [3:0] start_count;
    logic [3:0] stop_count;
    logic       violation;

    // Test table whose gap column is filled from the LCG
    logic [3:0] tbl_nack_at   [ROWS];
    logic [3:0] tbl_exp_count [ROWS];
    logic       tbl_exp_nack  [ROWS];
    int         tbl_gap       [ROWS];

    int          checks;
    int          errors;
    logic [31:0] rng_state;

    // Wired-AND bus where each side can only pull low
    assign scl_bus = ~scl_low;
    assign sda_bus = ~(sda_low_dut | sda_low_model);

    cpld_led_ctrl_top #(
        .QUARTER_DIV (16'(QDIV))
    ) cpld_led_ctrl_top_inst (
        .clk       (clk),
        .reset     (reset),
        .start_i   (start_i),
        .scl_i     (scl_bus),
        .sda_i     (sda_bus),
        .scl_low_o (scl_low),
        .sda_low_o (sda_low_dut),
        .busy_o    (busy),
        .done_o    (done),
        .nack_o    (nack)
    );

    i2c_target_model i2c_target_model_inst (
        .clk           (clk),
        .reset         (reset),
        .clear_i       (clear),
        .scl_i         (scl_bus),
        .sda_i         (sda_bus),
        .nack_at_i     (nack_at),
        .sda_low_o     (sda_low_model),
        .byte_count_o  (byte_count),
        .byte0_o       (byte0),
        .byte1_o       (byte1),
        .byte2_o       (byte2),
        .start_count_o (start_count),
        .stop_count_o  (stop_count),
        .violation_o   (violation)
    );

    //////////////////////////////
    // Clock and watchdog
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the transactions did not finish in %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Inputs change and outputs are read 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic check_idle_bus();
        check_value("scl_low_o while idle", 32'(scl_low), 32'd0);
        check_value("sda_low_o while idle", 32'(sda_low_dut), 32'd0);
        check_value("busy_o while idle", 32'(busy), 32'd0);
    endtask

    task automatic run_row(input int row);
        int gap_left;
        // Fresh target state and the NACK position for this row
        clear   = 1'b1;
        nack_at = tbl_nack_at[row];
        step_cycle();
        clear = 1'b0;
        for (gap_left = tbl_gap[row]; gap_left > 0; gap_left--) begin
            step_cycle();
        end
        check_idle_bus();
        start_i = 1'b1;
        step_cycle();
        start_i = 1'b0;
        // A second request in the middle of the transaction must be ignored
        repeat (12) step_cycle();
        check_value("busy_o during transaction", 32'(busy), 32'd1);
        start_i = 1'b1;
        step_cycle();
        start_i = 1'b0;
        while (done !== 1'b1) begin
            step_cycle();
        end
        check_value("nack_o at done_o", 32'(nack), 32'(tbl_exp_nack[row]));
        check_value("byte count", 32'(byte_count), 32'(tbl_exp_count[row]));
        check_value("byte 0", 32'(byte0), 32'(EXP_BYTE0));
        if (tbl_exp_count[row] > 4'd1) begin
            check_value("byte 1", 32'(byte1), 32'(EXP_BYTE1));
        end
        if (tbl_exp_count[row] > 4'd2) begin
            check_value("byte 2", 32'(byte2), 32'(EXP_BYTE2));
        end
        check_value("START count", 32'(start_count), 32'd1);
        check_value("STOP count", 32'(stop_count), 32'd1);
        // done_o is a single pulse and no second transaction follows
        repeat (POST_CYCLES) begin
            step_cycle();
            check_value("done_o after the pulse", 32'(done), 32'd0);
        end
        check_value("START count after row", 32'(start_count), 32'd1);
        check_value("nack_o held", 32'(nack), 32'(tbl_exp_nack[row]));
        if (violation) begin
            errors = errors + 1;
            $display("SDA moved while SCL was high outside START and STOP in row %0d", row);
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int row;
        reset     = 1'b1;
        start_i   = 1'b0;
        clear     = 1'b0;
        nack_at   = 4'hF;
        checks    = 0;
        errors    = 0;
        rng_state = 32'h36062673;

        // NACK position 4'hF means every byte is acknowledged
        tbl_nack_at   = '{4'hF, 4'd0, 4'd1, 4'd2, 4'hF, 4'd1};
        tbl_exp_count = '{4'd3, 4'd1, 4'd2, 4'd3, 4'd3, 4'd2};
        tbl_exp_nack  = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
        for (row = 0; row < ROWS; row++) begin
            rng_state    = lcg_next(rng_state);
            tbl_gap[row] = 1 + int'(rng_state[19:16]);
        end

        repeat (16) step_cycle();
        reset = 1'b0;
        step_cycle();
        check_idle_bus();

        for (row = 0; row < ROWS; row++) begin
            run_row(row);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== bench/i2c_target_model.sv ====
`timescale 1ns/1ps

module i2c_target_model (
    input  logic       clk,
    input  logic       reset,
    input  logic       clear_i,
    input  logic       scl_i,
    input  logic       sda_i,
    input  logic [3:0] nack_at_i,
    output logic       sda_low_o,
    output logic [3:0] byte_count_o,
    output logic [7:0] byte0_o,
    output logic [7:0] byte1_o,
    output logic [7:0] byte2_o,
    output logic [3:0] start_count_o,
    output logic [3:0] stop_count_o,
    output logic       violation_o
);

    // Bus levels seen one clk earlier for edge detection
    logic       scl_q;
    logic       sda_q;
    logic       in_txn_q;
    logic [3:0] bit_cnt_q;
    logic [7:0] shift_q;
    logic       scl_rise;
    logic       scl_fall;
    logic       start_cond;
    logic       stop_cond;

    assign scl_rise   = scl_i && !scl_q;
    assign scl_fall   = !scl_i && scl_q;
    // SDA moving while SCL stays high is a START or a STOP
    assign start_cond = scl_i && scl_q && sda_q && !sda_i;
    assign stop_cond  = scl_i && scl_q && !sda_q && sda_i;

    //////////////////////////////
    // Bus decoder
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scl_q         <= 1'b1;
            sda_q         <= 1'b1;
            in_txn_q      <= 1'b0;
            bit_cnt_q     <= 4'd0;
            shift_q       <= 8'd0;
            sda_low_o     <= 1'b0;
            byte_count_o  <= 4'd0;
            byte0_o       <= 8'd0;
            byte1_o       <= 8'd0;
            byte2_o       <= 8'd0;
            start_count_o <= 4'd0;
            stop_count_o  <= 4'd0;
            violation_o   <= 1'b0;
        end else begin
            scl_q <= scl_i;
            sda_q <= sda_i;
            if (clear_i) begin
                in_txn_q      <= 1'b0;
                bit_cnt_q     <= 4'd0;
                sda_low_o     <= 1'b0;
                byte_count_o  <= 4'd0;
                byte0_o       <= 8'd0;
                byte1_o       <= 8'd0;
                byte2_o       <= 8'd0;
                start_count_o <= 4'd0;
                stop_count_o  <= 4'd0;
                violation_o   <= 1'b0;
            end else if (start_cond) begin
                // A START inside a transaction means SDA moved during SCL high
                if (in_txn_q) begin
                    violation_o <= 1'b1;
                end
                in_txn_q      <= 1'b1;
                bit_cnt_q     <= 4'd0;
                start_count_o <= start_count_o + 4'd1;
            end else if (stop_cond) begin
                // The STOP clock itself counts as one sampled bit
                if (!in_txn_q || bit_cnt_q != 4'd1) begin
                    violation_o <= 1'b1;
                end
                in_txn_q     <= 1'b0;
                bit_cnt_q    <= 4'd0;
                stop_count_o <= stop_count_o + 4'd1;
            end else if (scl_rise && in_txn_q) begin
                if (bit_cnt_q < 4'd8) begin
                    shift_q   <= {shift_q[6:0], sda_i};
                    bit_cnt_q <= bit_cnt_q + 4'd1;
                end else if (bit_cnt_q == 4'd8) begin
                    bit_cnt_q <= 4'd9;
                end
            end else if (scl_fall && in_txn_q) begin
                if (bit_cnt_q == 4'd8) begin
                    case (byte_count_o)
                        4'd0:    byte0_o <= shift_q;
                        4'd1:    byte1_o <= shift_q;
                        4'd2:    byte2_o <= shift_q;
                        default: byte2_o <= byte2_o;
                    endcase
                    byte_count_o <= byte_count_o + 4'd1;
                    // ACK by pulling SDA low unless this byte is to be refused
                    sda_low_o    <= (byte_count_o != nack_at_i);
                end else if (bit_cnt_q == 4'd9) begin
                    sda_low_o <= 1'b0;
                    bit_cnt_q <= 4'd0;
                end
            end
        end
    end

endmodule

// ==== source/cpld_led_ctrl_top.sv ====
`timescale 1ns/1ps

module cpld_led_ctrl_top #(
    parameter i2c_pkg::div_cnt_t  QUARTER_DIV   = 16'd250,
    parameter int                 FILTER_STAGES = 2,
    parameter i2c_pkg::i2c_addr_t CPLD_ADDR     = 7'h3E,
    parameter i2c_pkg::i2c_byte_t CTRL_REG      = 8'h02,
    parameter i2c_pkg::i2c_byte_t LED_VALUE     = 8'h01
) (
    input  logic clk,
    input  logic reset,
    input  logic start_i,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl_low_o,
    output logic sda_low_o,
    output logic busy_o,
    output logic done_o,
    output logic nack_o
);

    // Command handshake between sequencer and engine
    logic               cmd_valid;
    logic               cmd_ready;
    logic               cmd_done;
    logic               cmd_nack;
    i2c_pkg::eng_cmd_t  cmd;
    i2c_pkg::i2c_byte_t cmd_byte;

    // Engine timing and bus readback
    logic               scl_run;
    logic               phase_tick;
    i2c_pkg::quarter_t  phase;
    logic               scl_filt;
    logic               sda_filt;

    //////////////////////////////
    // Bus input conditioning
    //////////////////////////////

    i2c_line_filter #(
        .FILTER_STAGES (FILTER_STAGES)
    ) i2c_line_filter_inst (
        .clk        (clk),
        .reset      (reset),
        .scl_i      (scl_i),
        .sda_i      (sda_i),
        .scl_filt_o (scl_filt),
        .sda_filt_o (sda_filt)
    );

    i2c_scl_timer #(
        .QUARTER_DIV (QUARTER_DIV)
    ) i2c_scl_timer_inst (
        .clk          (clk),
        .reset        (reset),
        .run_i        (scl_run),
        .phase_tick_o (phase_tick),
        .phase_o      (phase)
    );

    //////////////////////////////
    // Bit engine and sequencer
    //////////////////////////////

    i2c_byte_engine i2c_byte_engine_inst (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid_i  (cmd_valid),
        .cmd_i        (cmd),
        .cmd_byte_i   (cmd_byte),
        .cmd_ready_o  (cmd_ready),
        .cmd_done_o   (cmd_done),
        .cmd_nack_o   (cmd_nack),
        .phase_tick_i (phase_tick),
        .phase_i      (phase),
        .scl_filt_i   (scl_filt),
        .sda_filt_i   (sda_filt),
        .scl_run_o    (scl_run),
        .scl_low_o    (scl_low_o),
        .sda_low_o    (sda_low_o)
    );

    cpld_write_sequencer #(
        .CPLD_ADDR (CPLD_ADDR),
        .CTRL_REG  (CTRL_REG),
        .LED_VALUE (LED_VALUE)
    ) cpld_write_sequencer_inst (
        .clk         (clk),
        .reset       (reset),
        .start_i     (start_i),
        .cmd_ready_i (cmd_ready),
        .cmd_done_i  (cmd_done),
        .cmd_nack_i  (cmd_nack),
        .cmd_valid_o (cmd_valid),
        .cmd_o       (cmd),
        .cmd_byte_o  (cmd_byte),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .nack_o      (nack_o)
    );

endmodule

// ==== source/cpld_write_sequencer.sv ====
`timescale 1ns/1ps

module cpld_write_sequencer #(
    parameter i2c_pkg::i2c_addr_t CPLD_ADDR = 7'h3E,
    parameter i2c_pkg::i2c_byte_t CTRL_REG  = 8'h02,
    parameter i2c_pkg::i2c_byte_t LED_VALUE = 8'h01
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               start_i,
    input  logic               cmd_ready_i,
    input  logic               cmd_done_i,
    input  logic               cmd_nack_i,
    output logic               cmd_valid_o,
    output i2c_pkg::eng_cmd_t  cmd_o,
    output i2c_pkg::i2c_byte_t cmd_byte_o,
    output logic               busy_o,
    output logic               done_o,
    output logic               nack_o
);

    i2c_pkg::seq_state_t state_q;
    logic                cmd_valid_q;
    logic                done_q;
    logic                nack_seen_q;
    logic                nack_q;

    //////////////////////////////
    // Transaction FSM
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q     <= i2c_pkg::SEQ_IDLE;
            cmd_valid_q <= 1'b0;
            done_q      <= 1'b0;
            nack_seen_q <= 1'b0;
            nack_q      <= 1'b0;
        end else begin
            done_q <= 1'b0;
            // Drop the request once the engine has taken it
            if (cmd_valid_q && cmd_ready_i) begin
                cmd_valid_q <= 1'b0;
            end
            case (state_q)
                i2c_pkg::SEQ_IDLE: begin
                    if (start_i) begin
                        state_q     <= i2c_pkg::SEQ_START;
                        cmd_valid_q <= 1'b1;
                        nack_seen_q <= 1'b0;
                        nack_q      <= 1'b0;
                    end
                end
                i2c_pkg::SEQ_START: begin
                    if (cmd_done_i) begin
                        state_q     <= i2c_pkg::SEQ_ADDR;
                        cmd_valid_q <= 1'b1;
                    end
                end
                i2c_pkg::SEQ_ADDR, i2c_pkg::SEQ_REG, i2c_pkg::SEQ_VALUE: begin
                    if (cmd_done_i) begin
                        cmd_valid_q <= 1'b1;
                        if (cmd_nack_i) begin
                            // Remaining bytes are skipped and the bus is freed
                            nack_seen_q <= 1'b1;
                            state_q     <= i2c_pkg::SEQ_STOP;
                        end else if (state_q == i2c_pkg::SEQ_ADDR) begin
                            state_q <= i2c_pkg::SEQ_REG;
                        end else if (state_q == i2c_pkg::SEQ_REG) begin
                            state_q <= i2c_pkg::SEQ_VALUE;
                        end else begin
                            state_q <= i2c_pkg::SEQ_STOP;
                        end
                    end
                end
                i2c_pkg::SEQ_STOP: begin
                    if (cmd_done_i) begin
                        state_q <= i2c_pkg::SEQ_DONE;
                    end
                end
                default: begin
                    // Result and done are published together
                    done_q  <= 1'b1;
                    nack_q  <= nack_seen_q;
                    state_q <= i2c_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

    // Command and byte follow the state so they stay stable while valid is up
    always_comb begin
        cmd_o      = i2c_pkg::CMD_WRITE;
        cmd_byte_o = '0;
        case (state_q)
            i2c_pkg::SEQ_START: cmd_o      = i2c_pkg::CMD_START;
            i2c_pkg::SEQ_STOP:  cmd_o      = i2c_pkg::CMD_STOP;
            // Write direction bit is 0
            i2c_pkg::SEQ_ADDR:  cmd_byte_o = {CPLD_ADDR, 1'b0};
            i2c_pkg::SEQ_REG:   cmd_byte_o = CTRL_REG;
            i2c_pkg::SEQ_VALUE: cmd_byte_o = LED_VALUE;
            default:            cmd_byte_o = '0;
        endcase
    end

    assign cmd_valid_o = cmd_valid_q;
    assign busy_o      = (state_q != i2c_pkg::SEQ_IDLE);
    assign done_o      = done_q;
    assign nack_o      = nack_q;

endmodule

// ==== source/i2c_byte_engine.sv ====
`timescale 1ns/1ps

module i2c_byte_engine (
    input  logic               clk,
    input  logic               reset,
    input  logic               cmd_valid_i,
    input  i2c_pkg::eng_cmd_t  cmd_i,
    input  i2c_pkg::i2c_byte_t cmd_byte_i,
    output logic               cmd_ready_o,
    output logic               cmd_done_o,
    output logic               cmd_nack_o,
    input  logic               phase_tick_i,
    input  i2c_pkg::quarter_t  phase_i,
    input  logic               scl_filt_i,
    input  logic               sda_filt_i,
    output logic               scl_run_o,
    output logic               scl_low_o,
    output logic               sda_low_o
);

    i2c_pkg::engine_state_t state_q;
    i2c_pkg::i2c_byte_t     shift_q;
    i2c_pkg::bit_idx_t      bit_idx_q;
    logic                   scl_low_q;
    logic                   sda_low_q;
    logic                   done_q;
    logic                   nack_q;
    logic                   high_seen_q;
    logic                   high_event;

    // Commands are only taken while no bus operation is running
    assign cmd_ready_o = (state_q == i2c_pkg::ENG_IDLE);
    assign scl_run_o   = (state_q != i2c_pkg::ENG_IDLE);

    // First cycle inside the high quarter where SCL reads back high
    // This is where START and STOP move SDA and where ACK is sampled
    assign high_event = scl_run_o && !phase_tick_i && !high_seen_q
                        && (phase_i == i2c_pkg::Q_HIGH_SAMPLE) && scl_filt_i;

    //////////////////////////////
    // Byte register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (cmd_ready_o && cmd_valid_i && (cmd_i == i2c_pkg::CMD_WRITE)) begin
            shift_q <= cmd_byte_i;
        end
    end

    //////////////////////////////
    // Bit level FSM
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q     <= i2c_pkg::ENG_IDLE;
            bit_idx_q   <= 3'd7;
            scl_low_q   <= 1'b0;
            sda_low_q   <= 1'b0;
            done_q      <= 1'b0;
            nack_q      <= 1'b0;
            high_seen_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (state_q == i2c_pkg::ENG_IDLE) begin
                // Both lines hold their last level while waiting for a command
                if (cmd_valid_i) begin
                    case (cmd_i)
                        i2c_pkg::CMD_START: begin
                            state_q <= i2c_pkg::ENG_START;
                        end
                        i2c_pkg::CMD_WRITE: begin
                            state_q   <= i2c_pkg::ENG_SHIFT;
                            bit_idx_q <= 3'd7;
                        end
                        default: begin
                            state_q <= i2c_pkg::ENG_STOP;
                        end
                    endcase
                end
            end else if (phase_tick_i) begin
                case (phase_i)
                    i2c_pkg::Q_LOW_SETUP: begin
                        // SCL is low here so SDA may change for data and ACK
                        case (state_q)
                            i2c_pkg::ENG_SHIFT: sda_low_q <= ~shift_q[bit_idx_q];
                            i2c_pkg::ENG_ACK:   sda_low_q <= 1'b0;
                            i2c_pkg::ENG_STOP:  sda_low_q <= 1'b1;
                            default:            sda_low_q <= sda_low_q;
                        endcase
                    end
                    i2c_pkg::Q_RISE: begin
                        scl_low_q <= 1'b0;
                    end
                    i2c_pkg::Q_HIGH_SAMPLE: begin
                        // Arm the high event for this quarter
                        high_seen_q <= 1'b0;
                    end
                    default: begin
                        // Q_FALL ends the bit and in most cases the command
                        case (state_q)
                            i2c_pkg::ENG_SHIFT: begin
                                scl_low_q <= 1'b1;
                                if (bit_idx_q == 3'd0) begin
                                    state_q <= i2c_pkg::ENG_ACK;
                                    // Counts as NACK unless SDA is seen low
                                    nack_q  <= 1'b1;
                                end else begin
                                    bit_idx_q <= bit_idx_q - 3'd1;
                                end
                            end
                            i2c_pkg::ENG_STOP: begin
                                // SCL stays released once the bus is free
                                state_q <= i2c_pkg::ENG_IDLE;
                                done_q  <= 1'b1;
                            end
                            default: begin
                                scl_low_q <= 1'b1;
                                state_q   <= i2c_pkg::ENG_IDLE;
                                done_q    <= 1'b1;
                            end
                        endcase
                    end
                endcase
            end else if (high_event) begin
                high_seen_q <= 1'b1;
                case (state_q)
                    // SDA falls while SCL is high
                    i2c_pkg::ENG_START: sda_low_q <= 1'b1;
                    i2c_pkg::ENG_ACK:   nack_q    <= sda_filt_i;
                    // SDA rises while SCL is high
                    i2c_pkg::ENG_STOP:  sda_low_q <= 1'b0;
                    default:            sda_low_q <= sda_low_q;
                endcase
            end
        end
    end

    assign cmd_done_o = done_q;
    assign cmd_nack_o = nack_q;
    assign scl_low_o  = scl_low_q;
    assign sda_low_o  = sda_low_q;

endmodule

// ==== source/i2c_scl_timer.sv ====
`timescale 1ns/1ps

module i2c_scl_timer #(
    parameter i2c_pkg::div_cnt_t QUARTER_DIV = 16'd250
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              run_i,
    output logic              phase_tick_o,
    output i2c_pkg::quarter_t phase_o
);

    i2c_pkg::div_cnt_t cnt_q;
    i2c_pkg::quarter_t phase_q;

    //////////////////////////////
    // Quarter period divider
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt_q   <= '0;
            phase_q <= i2c_pkg::Q_LOW_SETUP;
        end else if (!run_i) begin
            // Idle bus keeps the divider parked at the start of a low phase
            cnt_q   <= '0;
            phase_q <= i2c_pkg::Q_LOW_SETUP;
        end else if (cnt_q == QUARTER_DIV - 16'd1) begin
            cnt_q   <= '0;
            // Enum order follows the bus order so the phase wraps after Q_FALL
            phase_q <= i2c_pkg::quarter_t'(phase_q + 2'd1);
        end else begin
            cnt_q <= cnt_q + 16'd1;
        end
    end

    // The tick marks the first cycle of each quarter
    // It fires on the very first cycle that run_i is high
    assign phase_tick_o = run_i && (cnt_q == '0);
    assign phase_o      = phase_q;

endmodule

// ==== source/i2c_line_filter.sv ====
`timescale 1ns/1ps

module i2c_line_filter #(
    parameter int FILTER_STAGES = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl_filt_o,
    output logic sda_filt_o
);

    // Run counter must be able to hold FILTER_STAGES - 1
    localparam int CNT_W = $clog2(FILTER_STAGES) + 1;

    // Index 0 is SCL and index 1 is SDA
    logic [1:0]       line_in;
    logic [1:0]       sync_q1;
    logic [1:0]       sync_q2;
    logic [1:0]       filt_q;
    logic [CNT_W-1:0] run_cnt_q [2];

    assign line_in = {sda_i, scl_i};

    // Both lines get the same synchronizer and run-length filter
    for (genvar i = 0; i < 2; i++) begin : g_line
        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                // Released bus level until the lines have been seen
                sync_q1[i]   <= 1'b1;
                sync_q2[i]   <= 1'b1;
                filt_q[i]    <= 1'b1;
                run_cnt_q[i] <= '0;
            end else begin
                sync_q1[i] <= line_in[i];
                sync_q2[i] <= sync_q1[i];
                if (sync_q2[i] == filt_q[i]) begin
                    // A sample equal to the output breaks any run in progress
                    run_cnt_q[i] <= '0;
                end else if (run_cnt_q[i] == CNT_W'(FILTER_STAGES - 1)) begin
                    filt_q[i]    <= sync_q2[i];
                    run_cnt_q[i] <= '0;
                end else begin
                    run_cnt_q[i] <= run_cnt_q[i] + CNT_W'(1);
                end
            end
        end
    end

    assign scl_filt_o = filt_q[0];
    assign sda_filt_o = filt_q[1];

endmodule

// ==== source/i2c_pkg.sv ====
package i2c_pkg;

    //////////////////////////////
    // Bus level data types
    //////////////////////////////

    // One byte as it is shifted on SDA
    typedef logic [7:0] i2c_byte_t;

    // Target address without the direction bit
    typedef logic [6:0] i2c_addr_t;

    // Bit position inside the byte being shifted, MSB first
    typedef logic [2:0] bit_idx_t;

    // Divider count for one SCL quarter period
    typedef logic [15:0] div_cnt_t;

    //////////////////////////////
    // Phases and state machines
    //////////////////////////////

    // The four quarters of one SCL period in the order they occur
    typedef enum logic [1:0] {
        Q_LOW_SETUP,
        Q_RISE,
        Q_HIGH_SAMPLE,
        Q_FALL
    } quarter_t;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_START,
        ENG_SHIFT,
        ENG_ACK,
        ENG_STOP
    } engine_state_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_ADDR,
        SEQ_REG,
        SEQ_VALUE,
        SEQ_STOP,
        SEQ_DONE
    } seq_state_t;

    // Commands that the sequencer hands to the byte engine
    typedef enum logic [1:0] {
        CMD_START,
        CMD_WRITE,
        CMD_STOP
    } eng_cmd_t;

endpackage
